/* slave_clock_sync.f */
+incdir+testbench
hw/clk_sync_pkg.sv
hw/frame_decode.sv
hw/seq_mult.sv
hw/kalman_engine.sv
hw/period_counter.sv
hw/slave_clock_sync.sv
testbench/tb_slave_clock_sync.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the slave clock sync testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_slave_clock_sync \
	-f slave_clock_sync.f \
	-Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_slave_clock_sync)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

/* testbench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Loop model state

est_t m_offset;
est_t m_rate;
est_t m_pred;
shift_t m_shift;
int m_lock_cnt;
logic m_rdy;

function automatic void reset_model();
	m_offset = '0;
	m_rate = '0;
	m_pred = '0;
	m_shift = '0;
	m_lock_cnt = 0;
	m_rdy = 1'b0;
endfunction

function automatic void lose_lock();
	m_lock_cnt = 0;
	m_rdy = 1'b0;
endfunction

// Top half of Q16.16 times unsigned Q0.32
function automatic est_t scale_q32(input est_t a, input logic [31:0] b);
	longint prod;
	prod = longint'(a) * longint'({32'h0000_0000, b});
	return est_t'(prod >>> 32);
endfunction

function automatic void kalman_step(input word_t meas);
	est_t err;
	est_t gain;
	int prev_shift;
	logic [31:0] pred_factor;
	prev_shift = int'(m_shift);
	pred_factor = TIME_Q32 << 1;
	// Window judged before the update
	if (m_offset < LOCK_LIMIT && m_offset > -LOCK_LIMIT) begin
		if (m_lock_cnt < CONV_COUNT)
			m_lock_cnt = m_lock_cnt + 1;
		if (m_lock_cnt >= CONV_COUNT)
			m_rdy = 1'b1;
	end else begin
		lose_lock();
	end
	err = est_t'({meas, 16'h0000}) - m_offset;
	gain = scale_q32(err, GAIN_Q32);
	m_offset = m_offset + gain;
	m_rate = m_rate + gain;
	m_offset = m_offset + scale_q32(m_rate, TIME_Q32) - est_t'(prev_shift * 131072);
	if (prev_shift != 0)
		m_shift = '0; // Never two in a row
	else if (m_pred >= SHIFT_LIMIT)
		m_shift = 2'sd1;
	else if (m_pred <= -SHIFT_LIMIT)
		m_shift = -2'sd1;
	else
		m_shift = '0;
	m_pred = m_offset + scale_q32(m_rate, pred_factor);
endfunction

////////////////////////////////////////////////////////////////////////////
// Period sequence

// Sync interval in cycles that carries the given shift
function automatic int next_period(input int shift);
	return CYCLE_PERIOD + shift;
endfunction

function automatic int interval_sum(input int count, input int shift);
	int total;
	int i;
	total = next_period(shift);
	for (i = 1; i < count; i++)
		total += next_period(0);
	return total;
endfunction

`endif

/* testbench/tb_slave_clock_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_slave_clock_sync;
	import clk_sync_pkg::*;

	localparam int FRAME_BASE = 16;
	localparam int CYCLE_PERIOD = 200;
	localparam logic [31:0] GAIN_Q32 = 32'h4000_0000;
	localparam logic [31:0] TIME_Q32 = 32'h2000_0000;
	localparam int CONV_COUNT = 3;
	localparam int TIMEOUT_CYCLES = 4096;
	localparam int UPDATE_WAIT = 150; // Longer than three multiplies
	localparam int NUM_MESSAGES = 53;
	localparam int WATCHDOG_CYCLES = NUM_MESSAGES * (TIMEOUT_CYCLES + 200);

	logic clk_i;
	logic arst_n_i;
	addr_t rx_addr_i;
	byte_t rx_data_i;
	logic rx_we_i;
	logic msg_rdy_i;
	node_t node_i;
	logic node_rdy_i;
	est_t offset_est_o;
	est_t rate_est_o;
	logic sync_rdy_o;
	logic sync_o;
	logic sync_phase_o;
	count_t local_count_o;

	int seed = 25;
	int cyc = 0;
	int edge_cyc[$];
	logic sync_prev;
	logic phase_exp;
	int count_prev;
	int count_exp;
	int check_cnt = 0;
	int est_err_cnt = 0;
	int period_err_cnt = 0;
	int phase_err_cnt = 0;
	event check_ev;

	`include "tb_ref_model.svh"

	slave_clock_sync #(
		.FRAME_BASE     (FRAME_BASE),
		.CYCLE_PERIOD   (CYCLE_PERIOD),
		.GAIN_Q32       (GAIN_Q32),
		.TIME_Q32       (TIME_Q32),
		.CONV_COUNT     (CONV_COUNT),
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) slave_clock_sync_i (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.rx_addr_i     (rx_addr_i),
		.rx_data_i     (rx_data_i),
		.rx_we_i       (rx_we_i),
		.msg_rdy_i     (msg_rdy_i),
		.node_i        (node_i),
		.node_rdy_i    (node_rdy_i),
		.offset_est_o  (offset_est_o),
		.rate_est_o    (rate_est_o),
		.sync_rdy_o    (sync_rdy_o),
		.sync_o        (sync_o),
		.sync_phase_o  (sync_phase_o),
		.local_count_o (local_count_o)
	);

	always #10 clk_i = ~clk_i; // 20 ns

	always @(posedge clk_i) cyc <= cyc + 1;

	////////////////////////////////////////////////////////////////////////////
	// Sync pulse monitor, sampled on the falling edge

	always @(negedge clk_i) begin
		if (!arst_n_i) begin
			sync_prev = 1'b0;
			phase_exp = 1'b1;
			count_prev = -1;
		end else begin
			// Counter restarts with each sync pulse, else counts up by one
			count_exp = (sync_o && !sync_prev) ? 0 : count_prev + 1;
			if (int'(local_count_o) != count_exp) begin
				$display("ERR %0t: local_count_o %0d, expected %0d", $time, local_count_o,
					count_exp);
				period_err_cnt++;
			end
			count_prev = int'(local_count_o);
			if (sync_o && !sync_prev) begin
				edge_cyc.push_back(cyc);
				if (sync_phase_o !== phase_exp) begin
					$display("ERR %0t: sync_phase_o %b, expected %b", $time, sync_phase_o,
						phase_exp);
					phase_err_cnt++;
				end
				phase_exp = !sync_phase_o;
			end
			sync_prev = sync_o;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare process

	initial begin
		forever begin
			@(check_ev);
			check_cnt++;
			if (offset_est_o !== m_offset) begin
				$display("ERR %0t: offset_est_o %0d, expected %0d", $time, offset_est_o,
					m_offset);
				est_err_cnt++;
			end
			if (rate_est_o !== m_rate) begin
				$display("ERR %0t: rate_est_o %0d, expected %0d", $time, rate_est_o, m_rate);
				est_err_cnt++;
			end
			if (sync_rdy_o !== m_rdy) begin
				$display("ERR %0t: sync_rdy_o %b, expected %b at lock count %0d", $time,
					sync_rdy_o, m_rdy, m_lock_cnt);
				est_err_cnt++;
			end
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_i);
		#2;
	endtask

	task automatic write_byte(input addr_t addr, input byte_t data);
		@(posedge clk_i);
		#2;
		rx_addr_i = addr;
		rx_data_i = data;
		rx_we_i = 1'b1;
		@(posedge clk_i);
		#2;
		rx_we_i = 1'b0;
	endtask

	task automatic apply_reset();
		arst_n_i = 1'b0;
		reset_model();
		repeat (5) @(posedge clk_i);
		#2;
		arst_n_i = 1'b1;
	endtask

	task automatic request_check();
		-> check_ev;
		@(posedge clk_i);
		#2;
	endtask

	task automatic send_message(input node_t node, input word_t flags, input word_t meas,
		input logic rdy);
		addr_t slot;
		addr_t decoy;
		slot = addr_t'(FRAME_BASE + OFFSET_OFS + 2 * int'(node));
		decoy = addr_t'(FRAME_BASE + OFFSET_OFS + 2 * int'(node ^ node_t'(1)));
		node_i = node;
		node_rdy_i = rdy;
		write_byte(addr_t'(FRAME_BASE + FLAGS_LO_OFS), flags[7:0]);
		write_byte(addr_t'(FRAME_BASE + FLAGS_HI_OFS), flags[15:8]);
		write_byte(slot, meas[7:0]);
		write_byte(slot + addr_t'(1), meas[15:8]);
		write_byte(decoy, ~meas[7:0]); // Neighbour slot must be ignored
		msg_rdy_i = 1'b1;
		wait_cycles(2);
		msg_rdy_i = 1'b0;
		wait_cycles(UPDATE_WAIT);
		if (rdy && flags[node])
			kalman_step(meas);
		request_check();
	endtask

	task automatic wait_sync_edges(input int target, output logic ok);
		int limit;
		int i;
		limit = (target - edge_cyc.size() + 1) * 2 * CYCLE_PERIOD;
		for (i = 0; i < limit && edge_cyc.size() < target; i++)
			@(posedge clk_i);
		#2;
		ok = edge_cyc.size() >= target;
		if (!ok) begin
			$display("Sync pulses stopped: %0d seen, %0d expected", edge_cyc.size(), target);
			period_err_cnt++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int first;
		int i;
		int shift;
		int sum;
		logic ok;
		node_t node;
		clk_i = 1'b0;
		arst_n_i = 1'b0;
		rx_addr_i = '0;
		rx_data_i = '0;
		rx_we_i = 1'b0;
		msg_rdy_i = 1'b0;
		node_i = '0;
		node_rdy_i = 1'b0;
		apply_reset();

		// Nominal period with zero estimates
		first = edge_cyc.size();
		wait_sync_edges(first + 4, ok);
		if (ok) begin
			for (i = 0; i < 3; i++) begin
				if (edge_cyc[first+i+1] - edge_cyc[first+i] != next_period(0)) begin
					$display("ERR %0t: sync interval %0d, expected %0d", $time,
						edge_cyc[first+i+1] - edge_cyc[first+i], next_period(0));
					period_err_cnt++;
				end
			end
		end

		// First message builds the prediction, second one shifts
		send_message(node_t'(0), 16'h0001, 16'd8, 1'b1);
		first = edge_cyc.size();
		send_message(node_t'(0), 16'h0001, 16'd8, 1'b1);
		shift = int'(m_shift);
		if (shift == 0) begin
			$display("Period correction not exercised, the model chose no shift");
			period_err_cnt++;
		end
		wait_sync_edges(first + 6, ok);
		if (ok) begin
			sum = edge_cyc[first+5] - edge_cyc[first];
			if (sum != interval_sum(5, shift)) begin
				$display("ERR %0t: five sync intervals sum to %0d, expected %0d", $time, sum,
					interval_sum(5, shift));
				period_err_cnt++;
			end
		end

		// Qualification
		apply_reset();
		send_message(node_t'(1), 16'h0002, 16'd40, 1'b0);
		send_message(node_t'(1), 16'h0001, 16'd40, 1'b1);
		send_message(node_t'(1), 16'h0002, 16'd40, 1'b1);

		for (i = 0; i < 40; i++) begin
			node = (i < 20) ? node_t'(1) : node_t'(2);
			send_message(node, word_t'($random(seed)) | (word_t'(1) << node),
				word_t'($random(seed) % 200), 1'b1);
		end

		// Lock, silence, relock, then a large offset
		apply_reset();
		for (i = 0; i < 3; i++)
			send_message(node_t'(3), 16'h0008, 16'd0, 1'b1);
		wait_cycles(TIMEOUT_CYCLES / 2);
		request_check();
		wait_cycles(TIMEOUT_CYCLES);
		lose_lock();
		request_check();
		for (i = 0; i < 3; i++)
			send_message(node_t'(3), 16'h0008, 16'd0, 1'b1);
		send_message(node_t'(3), 16'h0008, 16'd100, 1'b1);
		send_message(node_t'(3), 16'h0008, 16'd100, 1'b1);

		$display("Checks %0d, estimate errors %0d, period errors %0d, phase errors %0d",
			check_cnt, est_err_cnt, period_err_cnt, phase_err_cnt);
		if (est_err_cnt + period_err_cnt + phase_err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("Watchdog expired after %0d cycles, the run did not complete",
			WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/slave_clock_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module slave_clock_sync #(
	parameter int FRAME_BASE = 16,
	parameter int CYCLE_PERIOD = 200,
	parameter logic [31:0] GAIN_Q32 = 32'h4000_0000, // One quarter
	parameter logic [31:0] TIME_Q32 = 32'h2000_0000, // One eighth
	parameter int CONV_COUNT = 3,
	parameter int TIMEOUT_CYCLES = 4096
) (
	input  wire                      clk_i,
	input  wire                      arst_n_i,
	input  wire clk_sync_pkg::addr_t rx_addr_i,
	input  wire clk_sync_pkg::byte_t rx_data_i,
	input  wire                      rx_we_i,
	input  wire                      msg_rdy_i,
	input  wire clk_sync_pkg::node_t node_i,
	input  wire                      node_rdy_i,
	output clk_sync_pkg::est_t       offset_est_o,
	output clk_sync_pkg::est_t       rate_est_o,
	output logic                     sync_rdy_o,
	output logic                     sync_o,
	output logic                     sync_phase_o,
	output clk_sync_pkg::count_t     local_count_o
);
	import clk_sync_pkg::*;

	logic meas_valid;
	word_t meas_offset;
	logic shift_start;
	shift_t shift_value;

	////////////////////////////////////////////////////////////////////////////
	// Mailbox decode, tracking loop, local cycle counter

	frame_decode #(
		.FRAME_BASE (FRAME_BASE)
	) frame_decode_i (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.rx_addr_i     (rx_addr_i),
		.rx_data_i     (rx_data_i),
		.rx_we_i       (rx_we_i),
		.msg_rdy_i     (msg_rdy_i),
		.node_i        (node_i),
		.node_rdy_i    (node_rdy_i),
		.meas_valid_o  (meas_valid),
		.meas_offset_o (meas_offset)
	);

	kalman_engine #(
		.GAIN_Q32       (GAIN_Q32),
		.TIME_Q32       (TIME_Q32),
		.CONV_COUNT     (CONV_COUNT),
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) kalman_engine_i (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.meas_valid_i  (meas_valid),
		.meas_offset_i (meas_offset),
		.offset_est_o  (offset_est_o),
		.rate_est_o    (rate_est_o),
		.shift_value_o (shift_value),
		.shift_start_o (shift_start),
		.sync_rdy_o    (sync_rdy_o)
	);

	period_counter #(
		.CYCLE_PERIOD (CYCLE_PERIOD)
	) period_counter_i (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.shift_start_i (shift_start),
		.shift_value_i (shift_value),
		.local_count_o (local_count_o),
		.sync_o        (sync_o),
		.sync_phase_o  (sync_phase_o)
	);

endmodule

`default_nettype wire

/* hw/period_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module period_counter #(
	parameter int CYCLE_PERIOD = 200
) (
	input  wire                       clk_i,
	input  wire                       arst_n_i,
	input  wire                       shift_start_i,
	input  wire clk_sync_pkg::shift_t shift_value_i,
	output clk_sync_pkg::count_t      local_count_o,
	output logic                      sync_o,
	output logic                      sync_phase_o
);
	import clk_sync_pkg::*;

	localparam count_t BASE_PERIOD = count_t'(CYCLE_PERIOD - 1);
	localparam count_t HALF_PERIOD = count_t'(CYCLE_PERIOD / 2);

	count_t cur_period_q;
	count_t next_period_q; // Pending, takes effect one wrap later
	shift_t shift_q;
	logic wrap;

	assign wrap = local_count_o == cur_period_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			local_count_o <= '0;
			cur_period_q <= BASE_PERIOD;
			next_period_q <= BASE_PERIOD;
			shift_q <= '0;
			sync_o <= 1'b0;
			sync_phase_o <= 1'b0;
		end else begin
			if (shift_start_i)
				shift_q <= shift_value_i;

			if (local_count_o == HALF_PERIOD)
				sync_o <= 1'b0;

			if (wrap) begin
				local_count_o <= '0;
				sync_o <= 1'b1;
				sync_phase_o <= !sync_phase_o;
				next_period_q <= BASE_PERIOD + {{14{shift_q[1]}}, shift_q};
				cur_period_q <= next_period_q;
				// Consumed, unless a new one arrives on the wrap itself
				if (!shift_start_i)
					shift_q <= '0;
			end else begin
				local_count_o <= local_count_o + 1'b1;
			end
		end
	end

	a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		local_count_o <= cur_period_q);

endmodule

`default_nettype wire

/* hw/kalman_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module kalman_engine #(
	parameter logic [31:0] GAIN_Q32 = 32'h4000_0000,
	parameter logic [31:0] TIME_Q32 = 32'h2000_0000,
	parameter int CONV_COUNT = 3,
	parameter int TIMEOUT_CYCLES = 4096
) (
	input  wire                      clk_i,
	input  wire                      arst_n_i,
	input  wire                      meas_valid_i,
	input  wire clk_sync_pkg::word_t meas_offset_i,
	output clk_sync_pkg::est_t       offset_est_o,
	output clk_sync_pkg::est_t       rate_est_o,
	output clk_sync_pkg::shift_t     shift_value_o,
	output logic                     shift_start_o,
	output logic                     sync_rdy_o
);
	import clk_sync_pkg::*;

	localparam logic [31:0] PRED_Q32 = TIME_Q32 << 1;
	localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);
	localparam logic [TMO_W-1:0] TMO_LIMIT = TMO_W'(TIMEOUT_CYCLES);

	loop_state_e state_q;
	est_t pred_q;
	count_t lock_cnt_q;
	logic [TMO_W-1:0] tmo_q;

	logic mul_start_q;
	logic mul_done;
	logic [31:0] mul_a_q;
	logic [31:0] mul_b_q;
	logic [63:0] mul_y;

	est_t mul_hi;
	est_t meas_err;
	est_t shift_corr;
	shift_t shift_next;
	logic in_window;

	seq_mult #(
		.WIDTH (32)
	) seq_mult_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.start_i  (mul_start_q),
		.a_i      (mul_a_q),
		.b_i      (mul_b_q),
		.y_o      (mul_y),
		.done_o   (mul_done)
	);

	assign mul_hi = est_t'(mul_y[63:32]); // Q16.16 times Q0.32, keep top half
	assign meas_err = {meas_offset_i, 16'h0000} - offset_est_o;
	assign in_window = (offset_est_o < LOCK_LIMIT) && (offset_est_o > -LOCK_LIMIT);
	assign shift_corr = {{13{shift_value_o[1]}}, shift_value_o, 17'h00000};

	// A shift is never issued twice in a row
	always_comb begin
		shift_next = '0;
		if (shift_value_o == '0) begin
			if (pred_q >= SHIFT_LIMIT)
				shift_next = 2'sd1;
			else if (pred_q <= -SHIFT_LIMIT)
				shift_next = -2'sd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Multiplier operands

	always_ff @(posedge clk_i) begin
		case (state_q)
			IDLE: begin
				mul_a_q <= meas_err;
				mul_b_q <= GAIN_Q32;
			end
			GAIN_ADD: begin
				mul_a_q <= rate_est_o + mul_hi; // Rate after the gain step
				mul_b_q <= TIME_Q32;
			end
			SHIFT: begin
				mul_a_q <= rate_est_o;
				mul_b_q <= PRED_Q32;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Update sequence

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
			offset_est_o <= '0;
			rate_est_o <= '0;
			pred_q <= '0;
			shift_value_o <= '0;
			shift_start_o <= 1'b0;
			mul_start_q <= 1'b0;
			lock_cnt_q <= '0;
			sync_rdy_o <= 1'b0;
			tmo_q <= '0;
		end else begin
			mul_start_q <= 1'b0;
			shift_start_o <= 1'b0;

			if (meas_valid_i)
				tmo_q <= '0;
			else if (tmo_q != TMO_LIMIT)
				tmo_q <= tmo_q + 1'b1;
			if (tmo_q == TMO_LIMIT) begin // Link silent too long
				lock_cnt_q <= '0;
				sync_rdy_o <= 1'b0;
			end

			case (state_q)
				IDLE: begin
					if (meas_valid_i) begin // Busy states drop the message
						if (in_window) begin
							if (lock_cnt_q < count_t'(CONV_COUNT))
								lock_cnt_q <= lock_cnt_q + 1'b1;
							if (lock_cnt_q >= count_t'(CONV_COUNT - 1))
								sync_rdy_o <= 1'b1;
						end else begin
							lock_cnt_q <= '0;
							sync_rdy_o <= 1'b0;
						end
						mul_start_q <= 1'b1;
						state_q <= GAIN_MUL;
					end
				end
				GAIN_MUL: if (mul_done) state_q <= GAIN_ADD;
				GAIN_ADD: begin
					offset_est_o <= offset_est_o + mul_hi;
					rate_est_o <= rate_est_o + mul_hi;
					mul_start_q <= 1'b1;
					state_q <= RATE_MUL;
				end
				RATE_MUL: if (mul_done) state_q <= RATE_ADD;
				RATE_ADD: begin
					// Rate term in, previous correction out
					offset_est_o <= offset_est_o + mul_hi - shift_corr;
					shift_value_o <= shift_next;
					shift_start_o <= 1'b1; // High during SHIFT
					state_q <= SHIFT;
				end
				SHIFT: begin
					mul_start_q <= 1'b1;
					state_q <= PRED_MUL;
				end
				PRED_MUL: if (mul_done) state_q <= PRED_ADD;
				PRED_ADD: begin
					pred_q <= offset_est_o + mul_hi;
					state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	a_shift_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		shift_value_o != 2'b10);

	a_mul_in_state: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		mul_start_q |-> state_q inside {GAIN_MUL, RATE_MUL, PRED_MUL});

endmodule

`default_nettype wire

/* hw/seq_mult.sv */
`timescale 1ns/10ps
`default_nettype none

module seq_mult #(
	parameter int WIDTH = 32
) (
	input  wire                  clk_i,
	input  wire                  arst_n_i,
	input  wire                  start_i,
	input  wire [WIDTH-1:0]      a_i, // Signed
	input  wire [WIDTH-1:0]      b_i, // Unsigned
	output logic [2*WIDTH-1:0]   y_o,
	output logic                 done_o
);
	localparam int CNT_W = $clog2(WIDTH + 1);

	logic [WIDTH:0] acc_q; // Upper partial product, one guard bit
	logic [WIDTH-1:0] mcand_q;
	logic [WIDTH-1:0] mplier_q;
	logic [WIDTH:0] sum;
	logic [CNT_W-1:0] cnt_q;
	logic busy_q;

	assign sum = acc_q + (mplier_q[0] ? {mcand_q[WIDTH-1], mcand_q} : '0);
	assign y_o = {acc_q[WIDTH-1:0], mplier_q};

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			acc_q <= '0;
			mcand_q <= a_i;
			mplier_q <= b_i;
		end else if (busy_q) begin
			// Arithmetic shift right of the whole product register
			{acc_q, mplier_q} <= {sum[WIDTH], sum, mplier_q[WIDTH-1:1]};
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				cnt_q <= CNT_W'(WIDTH);
			end else if (busy_q) begin
				cnt_q <= cnt_q - 1'b1;
				if (cnt_q == CNT_W'(1)) begin
					busy_q <= 1'b0;
					done_o <= 1'b1; // Last step lands with this edge
				end
			end
		end
	end

	a_no_restart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		start_i |-> !busy_q);

endmodule

`default_nettype wire

/* hw/frame_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_decode #(
	parameter int FRAME_BASE = 16
) (
	input  wire                      clk_i,
	input  wire                      arst_n_i,
	input  wire clk_sync_pkg::addr_t rx_addr_i,
	input  wire clk_sync_pkg::byte_t rx_data_i,
	input  wire                      rx_we_i,
	input  wire                      msg_rdy_i,
	input  wire clk_sync_pkg::node_t node_i,
	input  wire                      node_rdy_i,
	output logic                     meas_valid_o,
	output clk_sync_pkg::word_t      meas_offset_o
);
	import clk_sync_pkg::*;

	localparam addr_t FLAGS_LO_ADDR = addr_t'(FRAME_BASE + FLAGS_LO_OFS);
	localparam addr_t FLAGS_HI_ADDR = addr_t'(FRAME_BASE + FLAGS_HI_OFS);
	localparam addr_t OFFSET_ADDR = addr_t'(FRAME_BASE + OFFSET_OFS);

	word_t flags_q;
	addr_t ofs_lo_addr;
	addr_t ofs_hi_addr;
	logic msg_rdy_q;
	logic msg_edge;

	// Own slot follows the flags word, two bytes per node
	assign ofs_lo_addr = OFFSET_ADDR + addr_t'({node_i, 1'b0});
	assign ofs_hi_addr = ofs_lo_addr + addr_t'(1);
	assign msg_edge = msg_rdy_i && !msg_rdy_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flags_q <= '0;
		end else if (rx_we_i) begin
			if (rx_addr_i == FLAGS_LO_ADDR)
				flags_q[7:0] <= rx_data_i;
			if (rx_addr_i == FLAGS_HI_ADDR)
				flags_q[15:8] <= rx_data_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_we_i && rx_addr_i == ofs_lo_addr)
			meas_offset_o[7:0] <= rx_data_i;
		if (rx_we_i && rx_addr_i == ofs_hi_addr)
			meas_offset_o[15:8] <= rx_data_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// Message completion

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			msg_rdy_q <= 1'b0;
			meas_valid_o <= 1'b0;
		end else begin
			msg_rdy_q <= msg_rdy_i;
			// Only a message that carries a measurement for this node counts
			meas_valid_o <= msg_edge && node_rdy_i && flags_q[node_i];
		end
	end

endmodule

`default_nettype wire

/* hw/clk_sync_pkg.sv */
`default_nettype none

package clk_sync_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	localparam int POINTER_WIDTH = 8;
	localparam int NODE_WIDTH = 2; // Up to four nodes per frame

	typedef logic [POINTER_WIDTH-1:0] addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [NODE_WIDTH-1:0] node_t;
	typedef logic [15:0] word_t;       // Flags word or offset in ticks
	typedef logic signed [31:0] est_t; // Q16.16 ticks
	typedef logic signed [1:0] shift_t;
	typedef logic [15:0] count_t;

	////////////////////////////////////////////////////////////////////////////
	// Frame layout, relative to the frame base

	localparam int FLAGS_LO_OFS = 2;
	localparam int FLAGS_HI_OFS = 3;
	localparam int OFFSET_OFS = 4; // Node n at 4+2n and 5+2n

	////////////////////////////////////////////////////////////////////////////
	// Loop thresholds in Q16.16

	localparam est_t LOCK_LIMIT = 32'sd81920;  // 1.25 ticks
	localparam est_t SHIFT_LIMIT = 32'sd65536; // One tick

	typedef enum logic [2:0] {
		IDLE,
		GAIN_MUL,
		GAIN_ADD,
		RATE_MUL,
		RATE_ADD,
		SHIFT,
		PRED_MUL,
		PRED_ADD
	} loop_state_e;

endpackage

`default_nettype wire
